/* hw/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Fetch address width, byte granular
`define FETCH_ADDR_W 48

// Memory request index, PC bits [21:3]
`define FETCH_INDEX_W 19

// One memory beat
`define FETCH_BEAT_W 64

// Beats in one 64-byte line
`define FETCH_BEATS 8

// Instruction buffer entries
// Power of two, at least two whole lines
`define FETCH_IBUF_DEPTH 16

`endif

/* hw/fetch_pkg.sv */
`include "fetch_defines.svh"

package fetch_pkg;

    // Byte address of a fetch, also the PC
    typedef logic [`FETCH_ADDR_W-1:0] pc_t;

    // Memory line request index
    typedef logic [`FETCH_INDEX_W-1:0] line_index_t;

    // Raw data of one beat
    typedef logic [`FETCH_BEAT_W-1:0] beat_t;

    // PC controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0, // Waiting for buffer room
        REQ   = 2'd1, // Request held on the channel
        WAIT  = 2'd2, // Beats of a live line arriving
        DRAIN = 2'd3  // Beats of a flushed line arriving
    } pc_state_e;

endpackage

/* hw/pc_ctrl.sv */
`timescale 1ns/10ps
`include "fetch_defines.svh"

module pc_ctrl (
    input  logic                   clock,
    input  logic                   reset_n,
    input  fetch_pkg::pc_t         boot_addr,       // Reset vector, any alignment
    input  logic                   interrupt_valid,
    input  fetch_pkg::pc_t         interrupt_addr,
    input  logic                   redirect_valid,  // Branch redirect from execute
    input  fetch_pkg::pc_t         redirect_target,
    input  logic                   line_room,       // Buffer can take a full line
    input  logic                   line_done,       // Eighth beat of the line this cycle
    output logic                   req_valid,
    output fetch_pkg::line_index_t req_index,
    input  logic                   req_ready,
    output fetch_pkg::pc_t         line_base,       // Address of the line in flight
    output logic                   flush
);

    localparam int BEAT_OFS = $clog2(`FETCH_BEAT_W / 8);                // Byte bits in a beat
    localparam int LINE_OFS = $clog2(`FETCH_BEATS * `FETCH_BEAT_W / 8); // Byte bits in a line
    localparam fetch_pkg::pc_t LINE_BYTES = fetch_pkg::pc_t'(1) << LINE_OFS;

    fetch_pkg::pc_state_e state;
    fetch_pkg::pc_t       pc;
    fetch_pkg::pc_t       reload_addr;
    logic                 reload;     // PC load this cycle
    logic                 start_req;  // Leave IDLE with a fresh line request
    logic                 flush_q;    // Pulse after every PC load
    logic                 drain_pend; // Flush arrived before the handshake finished

    // Clear the offset inside a 64-byte line
    function automatic fetch_pkg::pc_t align_line(input fetch_pkg::pc_t addr);
        return addr & ~(LINE_BYTES - fetch_pkg::pc_t'(1));
    endfunction

    // Interrupt beats redirect
    assign reload      = interrupt_valid | redirect_valid;
    assign reload_addr = align_line(interrupt_valid ? interrupt_addr : redirect_target);

    // A load on the same edge keeps us in IDLE so the old PC is never requested
    assign start_req = (state == fetch_pkg::IDLE) && !reload && line_room;

    assign req_valid = (state == fetch_pkg::REQ);

    // Flush pulse empties the buffer
    // Held through DRAIN so a stale line never lands, even with no beat counted yet
    assign flush = flush_q | (state == fetch_pkg::DRAIN);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= fetch_pkg::IDLE;
            pc         <= align_line(boot_addr);
            flush_q    <= 1'b0;
            drain_pend <= 1'b0;
        end else begin
            flush_q <= reload;

            if (reload)
                pc <= reload_addr;                       // New path, aligned down
            else if (state == fetch_pkg::WAIT && line_done)
                pc <= pc + LINE_BYTES;                   // Sequential next line

            // Remember a flush until the request leaves the channel
            if (state == fetch_pkg::REQ && !req_ready)
                drain_pend <= drain_pend | reload;
            else
                drain_pend <= 1'b0;

            case (state)
                fetch_pkg::IDLE: begin
                    if (start_req)
                        state <= fetch_pkg::REQ;
                end
                fetch_pkg::REQ: begin
                    if (req_ready) begin                  // Handshake completes
                        if (reload || drain_pend)
                            state <= fetch_pkg::DRAIN;    // Line already stale
                        else
                            state <= fetch_pkg::WAIT;
                    end
                end
                fetch_pkg::WAIT: begin
                    if (line_done)
                        state <= fetch_pkg::IDLE;         // Whole line in, even if reloading now
                    else if (reload)
                        state <= fetch_pkg::DRAIN;
                end
                default: begin                            // DRAIN
                    if (line_done)
                        state <= fetch_pkg::IDLE;         // PC already holds the new target
                end
            endcase
        end
    end

    // Line address and index captured once per request
    always_ff @(posedge clock) begin
        if (start_req) begin
            line_base <= pc;
            req_index <= pc[BEAT_OFS +: `FETCH_INDEX_W]; // PC bits [21:3]
        end
    end

    // Channel rule, request held until accepted
    assert property (@(posedge clock) disable iff (!reset_n)
        req_valid && !req_ready |=> req_valid && $stable(req_index))
        else $error("pc_ctrl: req_index changed while waiting for req_ready");

endmodule

/* hw/fetch_beat_counter.sv */
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_beat_counter (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             flush,      // Drop beats while high
    input  fetch_pkg::pc_t   line_base,  // Aligned address of the current line
    input  logic             resp_valid,
    input  fetch_pkg::beat_t resp_data,
    output logic             wr_en,
    output fetch_pkg::pc_t   wr_pc,
    output fetch_pkg::beat_t wr_data,
    output logic             line_done
);

    localparam int CNT_W    = $clog2(`FETCH_BEATS);
    localparam int BEAT_OFS = $clog2(`FETCH_BEAT_W / 8);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`FETCH_BEATS - 1);

    logic [CNT_W-1:0] beat_cnt; // Beats seen of the current line

    assign line_done = resp_valid && (beat_cnt == LAST_BEAT);

    // Beat address is line base plus 8 bytes per beat
    assign wr_pc   = line_base + fetch_pkg::pc_t'({beat_cnt, {BEAT_OFS{1'b0}}});
    assign wr_data = resp_data;
    assign wr_en   = resp_valid && !flush; // Flush covers every beat of a stale line

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt <= '0;
        end else begin
            if (resp_valid)
                beat_cnt <= beat_cnt + 1'b1;  // Wraps to zero on the last beat
        end
    end

    // Count only restarts at the end of a line
    assert property (@(posedge clock) disable iff (!reset_n)
        $past(beat_cnt != '0) && beat_cnt == '0 |-> $past(line_done))
        else $error("fetch_beat_counter: beat count wrapped without line_done");

endmodule

/* hw/ibuffer.sv */
`timescale 1ns/10ps
`include "fetch_defines.svh"

module ibuffer (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             flush,      // Empty the queue
    input  logic             wr_en,
    input  fetch_pkg::pc_t   wr_pc,
    input  fetch_pkg::beat_t wr_data,
    output logic             inst_valid,
    output fetch_pkg::pc_t   inst_pc,
    output fetch_pkg::beat_t inst_data,
    input  logic             inst_ready, // Decode takes the head beat
    output logic             line_room   // Space for one whole line
);

    localparam int DEPTH = `FETCH_IBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);
    localparam logic [PTR_W:0] ROOM_MAX = (PTR_W + 1)'(DEPTH - `FETCH_BEATS);

    fetch_pkg::pc_t   mem_pc   [DEPTH]; // Beat address per entry
    fetch_pkg::beat_t mem_data [DEPTH]; // Beat payload per entry

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;    // Entries held, 0..DEPTH
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == FULL_CNT);
    assign push = wr_en && !full;
    assign pop  = inst_valid && inst_ready;

    // Hidden during the flush cycle so no old beat leaks to decode
    assign inst_valid = (count != '0) && !flush;
    assign inst_pc    = mem_pc[rd_ptr];
    assign inst_data  = mem_data[rd_ptr];

    assign line_room = (count <= ROOM_MAX);

    // Storage, head slot is never overwritten while valid
    always_ff @(posedge clock) begin
        if (push) begin
            mem_pc[wr_ptr]   <= wr_pc;
            mem_data[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;  // Drop everything, old path is dead
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at DEPTH
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither, level unchanged
            endcase
        end
    end

    // Controller only requests with line_room, so a full queue never sees a beat
    assert property (@(posedge clock) disable iff (!reset_n)
        wr_en |-> !full)
        else $error("ibuffer: write while full, beat lost");

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_top (
    input  logic                   clock,
    input  logic                   reset_n,
    input  fetch_pkg::pc_t         boot_addr,
    input  logic                   interrupt_valid,
    input  fetch_pkg::pc_t         interrupt_addr,
    input  logic                   redirect_valid,
    input  fetch_pkg::pc_t         redirect_target,
    output logic                   req_valid,       // Memory request channel
    output fetch_pkg::line_index_t req_index,
    input  logic                   req_ready,
    input  logic                   resp_valid,      // Memory beats, no back-pressure
    input  fetch_pkg::beat_t       resp_data,
    output logic                   inst_valid,      // Decode side
    output fetch_pkg::pc_t         inst_pc,
    output fetch_pkg::beat_t       inst_data,
    input  logic                   inst_ready
);

    fetch_pkg::pc_t   line_base;
    fetch_pkg::pc_t   wr_pc;
    fetch_pkg::beat_t wr_data;
    logic             flush;
    logic             wr_en;
    logic             line_done;
    logic             line_room;

    // PC, request channel and flush control
    pc_ctrl pc_ctrl_i (
        .clock(clock), .reset_n(reset_n),
        .boot_addr(boot_addr),
        .interrupt_valid(interrupt_valid), .interrupt_addr(interrupt_addr),
        .redirect_valid(redirect_valid), .redirect_target(redirect_target),
        .line_room(line_room), .line_done(line_done),
        .req_valid(req_valid), .req_index(req_index), .req_ready(req_ready),
        .line_base(line_base), .flush(flush)
    );

    // Tags each returning beat with its address
    fetch_beat_counter beat_cnt_i (
        .clock(clock), .reset_n(reset_n),
        .flush(flush), .line_base(line_base),
        .resp_valid(resp_valid), .resp_data(resp_data),
        .wr_en(wr_en), .wr_pc(wr_pc), .wr_data(wr_data),
        .line_done(line_done)
    );

    ibuffer ibuffer_i (
        .clock(clock), .reset_n(reset_n),
        .flush(flush),
        .wr_en(wr_en), .wr_pc(wr_pc), .wr_data(wr_data),
        .inst_valid(inst_valid), .inst_pc(inst_pc), .inst_data(inst_data),
        .inst_ready(inst_ready), .line_room(line_room)
    );

endmodule

/* dv/fetch_tb.sv */
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_tb;

    localparam int NUM_BEATS   = 3000;            // Consumed beats per run
    localparam int NUM_RELOADS = 40;              // Redirects plus interrupts
    localparam int MAX_CYCLES  = NUM_BEATS * 10;  // Generous bound on beat rate
    localparam fetch_pkg::beat_t DATA_KEY = 64'h5a3c_96e1_0f87_d2b4;

    logic                   clock;
    logic                   reset_n;
    fetch_pkg::pc_t         boot_addr;
    logic                   interrupt_valid;
    fetch_pkg::pc_t         interrupt_addr;
    logic                   redirect_valid;
    fetch_pkg::pc_t         redirect_target;
    logic                   req_valid;
    fetch_pkg::line_index_t req_index;
    logic                   req_ready;
    logic                   resp_valid;
    fetch_pkg::beat_t       resp_data;
    logic                   inst_valid;
    fetch_pkg::pc_t         inst_pc;
    fetch_pkg::beat_t       inst_data;
    logic                   inst_ready;

    fetch_pkg::pc_t         exp_pc;          // Next address decode should see
    fetch_pkg::line_index_t boot_index;
    fetch_pkg::line_index_t mem_index;       // Line being returned by memory
    fetch_pkg::line_index_t held_index;
    logic                   req_held;        // Request seen waiting last cycle
    logic                   first_req_seen;
    int beat_no;
    int beats_left;
    int cycles;
    int consumed;
    int reloads;
    int reload_gap;                          // Cycles until the next reload
    int checks;
    int errors;

    fetch_top dut_i (.*);

    always #2 clock = ~clock;

    // 64-byte line address
    function automatic fetch_pkg::pc_t align_down(input fetch_pkg::pc_t addr);
        return addr & ~fetch_pkg::pc_t'(63);
    endfunction

    // Memory rule, address bits [21:3] zero-extended then XOR key
    function automatic fetch_pkg::beat_t data_of(input fetch_pkg::line_index_t index);
        return fetch_pkg::beat_t'(index) ^ DATA_KEY;
    endfunction

    function automatic fetch_pkg::pc_t random_addr();
        return fetch_pkg::pc_t'({$urandom(), $urandom()});
    endfunction

    task automatic check_pc(input string name, input fetch_pkg::pc_t expected,
                            input fetch_pkg::pc_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_beat(input string name, input fetch_pkg::beat_t expected,
                              input fetch_pkg::beat_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_index(input string name, input fetch_pkg::line_index_t expected,
                               input fetch_pkg::line_index_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Late in the cycle, all values are what the next edge will capture
    task automatic sample_cycle();
        if (cycles == 0) begin
            check_bit("reset req_valid", 1'b0, req_valid);
            check_bit("reset inst_valid", 1'b0, inst_valid);
        end
        if (req_held) begin                                  // Channel must hold
            check_bit("request hold valid", 1'b1, req_valid);
            check_index("request hold index", held_index, req_index);
        end
        if (req_valid && !first_req_seen) begin
            check_index("boot index", boot_index, req_index);
            first_req_seen = 1'b1;
        end
        // Beat taken on this edge still belongs to the old path
        if (inst_valid && inst_ready) begin
            check_pc("stream pc", exp_pc, inst_pc);
            check_beat("stream data", data_of(exp_pc[`FETCH_INDEX_W+2:3]), inst_data);
            exp_pc = exp_pc + fetch_pkg::pc_t'(8);
            consumed++;
        end
        if (interrupt_valid)
            exp_pc = align_down(interrupt_addr);             // Interrupt wins
        else if (redirect_valid)
            exp_pc = align_down(redirect_target);
        if (req_valid && req_ready) begin                    // Line accepted by memory
            mem_index  = req_index;
            beat_no    = 0;
            beats_left = `FETCH_BEATS;
        end
        req_held   = req_valid && !req_ready;
        held_index = req_index;
    endtask

    // Just after the edge
    task automatic drive_cycle();
        int kind;
        req_ready  = ($urandom_range(0, 1) == 1);
        inst_ready = ($urandom_range(0, 9) < 6);             // About 60 percent
        resp_valid = (beats_left > 0) && ($urandom_range(0, 3) != 0);
        resp_data  = '0;
        if (resp_valid) begin
            resp_data = data_of(mem_index + fetch_pkg::line_index_t'(beat_no));
            beat_no++;
            beats_left--;
        end
        interrupt_valid = 1'b0;
        redirect_valid  = 1'b0;
        if (reloads < NUM_RELOADS) begin
            if (reload_gap == 0) begin
                kind            = $urandom_range(0, 3);
                redirect_valid  = (kind != 2);
                interrupt_valid = (kind >= 2);              // 3 gives both at once
                redirect_target = random_addr();
                interrupt_addr  = random_addr();
                reloads++;
                // One in four follows almost at once
                reload_gap = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 3)
                                                          : $urandom_range(80, 220);
            end else begin
                reload_gap--;
            end
        end
    endtask

    initial begin
        void'($urandom(6));
        clock           = 1'b0;
        reset_n         = 1'b0;
        boot_addr       = random_addr();
        interrupt_valid = 1'b0;
        interrupt_addr  = '0;
        redirect_valid  = 1'b0;
        redirect_target = '0;
        req_ready       = 1'b0;
        resp_valid      = 1'b0;
        resp_data       = '0;
        inst_ready      = 1'b0;
        exp_pc          = align_down(boot_addr);
        boot_index      = boot_addr[`FETCH_INDEX_W+2:3] & ~fetch_pkg::line_index_t'(7);
        mem_index       = '0;
        held_index      = '0;
        req_held        = 1'b0;
        first_req_seen  = 1'b0;
        beat_no         = 0;
        beats_left      = 0;
        cycles          = 0;
        consumed        = 0;
        reloads         = 0;
        reload_gap      = $urandom_range(80, 220);
        checks          = 0;
        errors          = 0;

        repeat (2) @(posedge clock);
        #0.5;
        reset_n = 1'b1;

        while (consumed < NUM_BEATS && cycles < MAX_CYCLES) begin
            #3.0;
            sample_cycle();
            cycles++;
            @(posedge clock);
            #0.5;
            drive_cycle();
        end

        if (consumed < NUM_BEATS) begin
            errors++;
            $display("Run timed out after %0d cycles with %0d of %0d beats consumed",
                     cycles, consumed, NUM_BEATS);
        end
        $display("Beats %0d, reloads %0d, checks %0d, errors %0d",
                 consumed, reloads, checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* all.f */
+incdir+hw
hw/fetch_pkg.sv
hw/pc_ctrl.sv
hw/fetch_beat_counter.sv
hw/ibuffer.sv
hw/fetch_top.sv
dv/fetch_tb.sv

/* Makefile */
# Verilator flow for the fetch frontend
# Every variable below can be overridden, e.g. make sim LOG=run2.log

SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= SOME TESTS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/$(TOP): $(FILELIST) $(wildcard hw/*.sv hw/*.svh dv/*.sv)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

sim: $(OBJ_DIR)/$(TOP)
	set -o pipefail; ./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation finished without failures"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
